/* hw/rdmx_pkg.sv */
// RDMX transmit path shared widths, fixed header constants and header word types
package rdmx_pkg;

   // ========================================
   // Bus widths
   // ========================================

   // Output and payload bus, one 64-byte header fits one beat
   localparam int data_wbits = 512;
   // Bytes per beat, also keep mask width
   localparam int keep_wbits = data_wbits / 8;
   localparam int addr_wbits = 64;
   // Payload length in bytes
   localparam int len_wbits  = 16;

   // ========================================
   // Header byte counts and fixed fields
   // ========================================

   localparam int ip_hdr_len   = 20;
   localparam int udp_hdr_len  = 8;
   localparam int rdmx_hdr_len = 22;

   localparam logic [15:0] rdmx_magic     = 16'h0122;
   localparam logic [15:0] eth_frame_type = 16'h0800;
   // Version 4, IHL 5, DSF zero
   localparam logic [15:0] ip4_ver_dsf    = 16'h4500;
   localparam logic [15:0] ip4_id         = 16'hDEAD;
   // Don't-fragment set, offset zero
   localparam logic [15:0] ip4_flags      = 16'h4000;
   // TTL 64, protocol UDP
   localparam logic [15:0] ip4_ttl_prot   = 16'h4011;
   // Upper 40 bits of the source MAC
   localparam logic [39:0] mac_prefix     = 40'hC400AD0000;

   // Header fields in wire order, first byte on the wire in the top bits
   typedef struct packed {
      logic [47:0] dst_mac;
      logic [47:0] src_mac;
      logic [15:0] frame_type;
      // IPv4, ten words
      logic [15:0] ip_ver_dsf;
      logic [15:0] ip_length;
      logic [15:0] ip_id;
      logic [15:0] ip_flags;
      logic [15:0] ip_ttl_prot;
      logic [15:0] ip_checksum;
      logic [15:0] ip_src_hi;
      logic [15:0] ip_src_lo;
      logic [15:0] ip_dst_hi;
      logic [15:0] ip_dst_lo;
      // UDP
      logic [15:0] udp_src_port;
      logic [15:0] udp_dst_port;
      logic [15:0] udp_length;
      logic [15:0] udp_checksum;
      // RDMX
      logic [15:0] magic;
      logic [63:0] addr;
      logic [95:0] reserved;
   } rdmx_hdr_t;

   // Same 512 bits seen as fields or as bytes, bytes[63] is wire byte 0
   typedef union packed {
      rdmx_hdr_t                   fields;
      logic [keep_wbits-1:0][7:0] bytes;
   } rdmx_hdr_word_u;

endpackage

/* hw/rdmx_stream_fifo.sv */
// Synchronous show-ahead FIFO with valid/ready handshakes on both sides
module rdmx_stream_fifo #(
   parameter int width = 8,
   parameter int depth = 4
) (
   input  logic             dst_clk,
   input  logic             dst_resetn,
   input  logic [width-1:0] in_data,
   input  logic             in_valid,
   output logic             in_ready,
   output logic [width-1:0] out_data,
   output logic             out_valid,
   input  logic             out_ready
);

   localparam int ptr_wbits = (depth > 1) ? $clog2(depth) : 1;
   localparam int cnt_wbits = $clog2(depth + 1);

   // Storage, no reset on the payload
   logic [width-1:0]     mem [depth];
   logic [ptr_wbits-1:0] wr_ptr;
   logic [ptr_wbits-1:0] rd_ptr;
   // Occupancy, 0 to depth
   logic [cnt_wbits-1:0] count;
   logic                 push;
   logic                 pop;

   // Space left means input accepted
   assign in_ready  = (count != cnt_wbits'(depth));
   // Head entry is always presented
   assign out_valid = (count != '0);
   assign out_data  = mem[rd_ptr];

   assign push = in_valid & in_ready;
   assign pop  = out_valid & out_ready;

   always_ff @(posedge dst_clk) begin
      if (push) begin
         mem[wr_ptr] <= in_data;
      end
   end

   // ========================================
   // Pointers and count
   // ========================================
   always_ff @(posedge dst_clk) begin
      if (!dst_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         // Wrap explicitly, depth need not be a power of two
         if (push) begin
            wr_ptr <= (wr_ptr == ptr_wbits'(depth - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == ptr_wbits'(depth - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // Simultaneous push and pop leaves count unchanged
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

/* hw/rdmx_header_builder.sv */
// RDMX header builder, forms the little-endian 64-byte Eth/IPv4/UDP/RDMX header beat
module rdmx_header_builder #(
   parameter logic [7:0]  src_mac_low = 8'h02,
   parameter logic [31:0] src_ip      = 32'h0A01_0102,
   parameter logic [31:0] dst_ip      = 32'h0A01_01FF,
   parameter logic [15:0] src_port    = 16'd1000,
   parameter logic [15:0] dst_port    = 16'd32002
) (
   input  logic [rdmx_pkg::len_wbits-1:0]  hdr_length,
   input  logic [rdmx_pkg::addr_wbits-1:0] hdr_addr,
   output logic [rdmx_pkg::data_wbits-1:0] hdr_word
);

   import rdmx_pkg::*;

   // Fixed parts of the IPv4 and UDP lengths
   localparam logic [15:0] ip_len_base  = 16'(ip_hdr_len + udp_hdr_len + rdmx_hdr_len);
   localparam logic [15:0] udp_len_base = 16'(udp_hdr_len + rdmx_hdr_len);

   logic [15:0]    ip_length;
   logic [15:0]    udp_length;
   logic [31:0]    cs32;
   logic [15:0]    ip_checksum;
   rdmx_hdr_word_u hdr;

   assign ip_length  = ip_len_base + hdr_length;
   assign udp_length = udp_len_base + hdr_length;

   // ========================================
   // IPv4 header checksum
   // ========================================

   // Nine nonzero words, checksum field itself counts as zero
   assign cs32 = 32'(ip4_ver_dsf) + 32'(ip4_id) + 32'(ip4_flags) + 32'(ip4_ttl_prot)
               + 32'(src_ip[31:16]) + 32'(src_ip[15:0])
               + 32'(dst_ip[31:16]) + 32'(dst_ip[15:0])
               + 32'(ip_length);

   // One fold of the carries, then ones complement
   assign ip_checksum = ~(cs32[15:0] + cs32[31:16]);

   // ========================================
   // Field fill and byte reversal
   // ========================================
   always_comb begin
      // Ethernet, broadcast destination
      hdr.fields.dst_mac      = '1;
      hdr.fields.src_mac      = {mac_prefix, src_mac_low};
      hdr.fields.frame_type   = eth_frame_type;
      // IPv4
      hdr.fields.ip_ver_dsf   = ip4_ver_dsf;
      hdr.fields.ip_length    = ip_length;
      hdr.fields.ip_id        = ip4_id;
      hdr.fields.ip_flags     = ip4_flags;
      hdr.fields.ip_ttl_prot  = ip4_ttl_prot;
      hdr.fields.ip_checksum  = ip_checksum;
      hdr.fields.ip_src_hi    = src_ip[31:16];
      hdr.fields.ip_src_lo    = src_ip[15:0];
      hdr.fields.ip_dst_hi    = dst_ip[31:16];
      hdr.fields.ip_dst_lo    = dst_ip[15:0];
      // UDP, checksum unused
      hdr.fields.udp_src_port = src_port;
      hdr.fields.udp_dst_port = dst_port;
      hdr.fields.udp_length   = udp_length;
      hdr.fields.udp_checksum = '0;
      // RDMX
      hdr.fields.magic        = rdmx_magic;
      hdr.fields.addr         = hdr_addr;
      hdr.fields.reserved     = '0;

      // MAC sends byte 0 first from bits 7:0, so wire byte 0 goes lowest
      for (int i = 0; i < keep_wbits; i++) begin
         hdr_word[i*8 +: 8] = hdr.bytes[keep_wbits-1-i];
      end
   end

endmodule

/* hw/rdmx_tx_sequencer.sv */
// RDMX transmit sequencer, pairs length and address, sends header then payload beats
module rdmx_tx_sequencer (
   input  logic                            dst_clk,
   input  logic                            dst_resetn,
   // Length FIFO head
   input  logic [rdmx_pkg::len_wbits-1:0]  len_data,
   input  logic                            len_valid,
   output logic                            len_ready,
   // Address FIFO head
   input  logic [rdmx_pkg::addr_wbits-1:0] addr_data,
   input  logic                            addr_valid,
   output logic                            addr_ready,
   // Data FIFO head
   input  logic [rdmx_pkg::data_wbits-1:0] pay_data,
   input  logic                            pay_last,
   input  logic                            pay_valid,
   output logic                            pay_ready,
   // Header builder
   output logic [rdmx_pkg::len_wbits-1:0]  hdr_length,
   output logic [rdmx_pkg::addr_wbits-1:0] hdr_addr,
   input  logic [rdmx_pkg::data_wbits-1:0] hdr_word,
   // Output stream
   output logic [rdmx_pkg::data_wbits-1:0] tx_tdata,
   output logic [rdmx_pkg::keep_wbits-1:0] tx_tkeep,
   output logic                            tx_tlast,
   output logic                            tx_valid,
   input  logic                            tx_ready
);

   import rdmx_pkg::*;

   // Bits of the length that give the bytes in a partial last beat
   localparam int rem_wbits = $clog2(keep_wbits);

   localparam logic [1:0] wait_meta    = 2'd0;
   localparam logic [1:0] send_header  = 2'd1;
   localparam logic [1:0] send_payload = 2'd2;

   logic [1:0]           state;
   logic                 meta_pop;
   logic [rem_wbits-1:0] extra_bytes;

   // ========================================
   // FIFO pops
   // ========================================

   // Length and address leave their FIFOs together
   assign meta_pop   = (state == wait_meta) & len_valid & addr_valid;
   assign len_ready  = meta_pop;
   assign addr_ready = meta_pop;

   // Payload moves only while the output takes it
   assign pay_ready  = (state == send_payload) & tx_ready;

   // ========================================
   // Output stream
   // ========================================
   assign tx_valid = (state == send_header) | ((state == send_payload) & pay_valid);
   assign tx_tdata = (state == send_payload) ? pay_data : hdr_word;
   assign tx_tlast = (state == send_payload) & pay_last;

   assign extra_bytes = hdr_length[rem_wbits-1:0];

   // Partial keep on the last beat only, full beat when remainder is zero
   always_comb begin
      tx_tkeep = '1;
      if (tx_tlast && extra_bytes != '0) begin
         tx_tkeep = (keep_wbits'(1) << extra_bytes) - 1'b1;
      end
   end

   // Latches for the packet in flight
   always_ff @(posedge dst_clk) begin
      if (meta_pop) begin
         hdr_length <= len_data;
         hdr_addr   <= addr_data;
      end
   end

   // ========================================
   // State machine
   // ========================================
   always_ff @(posedge dst_clk) begin
      if (!dst_resetn) begin
         state <= wait_meta;
      end else begin
         case (state)
            wait_meta: begin
               if (meta_pop) begin
                  state <= send_header;
               end
            end
            // Header beat held until accepted
            send_header: begin
               if (tx_ready) begin
                  state <= send_payload;
               end
            end
            send_payload: begin
               if (pay_valid && pay_ready && pay_last) begin
                  state <= wait_meta;
               end
            end
            default: begin
               state <= wait_meta;
            end
         endcase
      end
   end

endmodule

/* hw/rdmx_xmit.sv */
// RDMX transmit top level, input FIFOs feeding the header builder and sequencer
module rdmx_xmit #(
   parameter logic [7:0]  src_mac_low     = 8'h02,
   parameter logic [31:0] src_ip          = 32'h0A01_0102,
   parameter logic [31:0] dst_ip          = 32'h0A01_01FF,
   parameter logic [15:0] src_port        = 16'd1000,
   parameter logic [15:0] dst_port        = 16'd32002,
   parameter int          data_fifo_depth = 16,
   parameter int          meta_fifo_depth = 4
) (
   input  logic                            dst_clk,
   input  logic                            dst_resetn,
   // Payload data stream
   input  logic [rdmx_pkg::data_wbits-1:0] data_tdata,
   input  logic                            data_tlast,
   input  logic                            data_valid,
   output logic                            data_ready,
   // Payload length stream, bytes
   input  logic [rdmx_pkg::len_wbits-1:0]  len_tdata,
   input  logic                            len_valid,
   output logic                            len_ready,
   // Target address stream
   input  logic [rdmx_pkg::addr_wbits-1:0] addr_tdata,
   input  logic                            addr_valid,
   output logic                            addr_ready,
   // Outgoing packet stream
   output logic [rdmx_pkg::data_wbits-1:0] tx_tdata,
   output logic [rdmx_pkg::keep_wbits-1:0] tx_tkeep,
   output logic                            tx_tlast,
   output logic                            tx_valid,
   input  logic                            tx_ready
);

   import rdmx_pkg::*;

   // ========================================
   // FIFO heads
   // ========================================

   // Last rides as the top bit of the data FIFO word
   logic [data_wbits:0]   pay_word;
   logic                  pay_valid;
   logic                  pay_ready;
   logic [len_wbits-1:0]  fifo_len;
   logic                  fifo_len_valid;
   logic                  fifo_len_ready;
   logic [addr_wbits-1:0] fifo_addr;
   logic                  fifo_addr_valid;
   logic                  fifo_addr_ready;
   // Header builder link
   logic [len_wbits-1:0]  hdr_length;
   logic [addr_wbits-1:0] hdr_addr;
   logic [data_wbits-1:0] hdr_word;

   rdmx_stream_fifo #(.width(data_wbits + 1), .depth(data_fifo_depth)) data_fifo (
      .dst_clk    (dst_clk),
      .dst_resetn (dst_resetn),
      .in_data    ({data_tlast, data_tdata}),
      .in_valid   (data_valid),
      .in_ready   (data_ready),
      .out_data   (pay_word),
      .out_valid  (pay_valid),
      .out_ready  (pay_ready)
   );

   rdmx_stream_fifo #(.width(len_wbits), .depth(meta_fifo_depth)) len_fifo (
      .dst_clk    (dst_clk),
      .dst_resetn (dst_resetn),
      .in_data    (len_tdata),
      .in_valid   (len_valid),
      .in_ready   (len_ready),
      .out_data   (fifo_len),
      .out_valid  (fifo_len_valid),
      .out_ready  (fifo_len_ready)
   );

   rdmx_stream_fifo #(.width(addr_wbits), .depth(meta_fifo_depth)) addr_fifo (
      .dst_clk    (dst_clk),
      .dst_resetn (dst_resetn),
      .in_data    (addr_tdata),
      .in_valid   (addr_valid),
      .in_ready   (addr_ready),
      .out_data   (fifo_addr),
      .out_valid  (fifo_addr_valid),
      .out_ready  (fifo_addr_ready)
   );

   // ========================================
   // Header and sequencing
   // ========================================
   rdmx_header_builder #(
      .src_mac_low (src_mac_low),
      .src_ip      (src_ip),
      .dst_ip      (dst_ip),
      .src_port    (src_port),
      .dst_port    (dst_port)
   ) header_builder (
      .hdr_length (hdr_length),
      .hdr_addr   (hdr_addr),
      .hdr_word   (hdr_word)
   );

   rdmx_tx_sequencer tx_sequencer (
      .dst_clk    (dst_clk),
      .dst_resetn (dst_resetn),
      .len_data   (fifo_len),
      .len_valid  (fifo_len_valid),
      .len_ready  (fifo_len_ready),
      .addr_data  (fifo_addr),
      .addr_valid (fifo_addr_valid),
      .addr_ready (fifo_addr_ready),
      .pay_data   (pay_word[data_wbits-1:0]),
      .pay_last   (pay_word[data_wbits]),
      .pay_valid  (pay_valid),
      .pay_ready  (pay_ready),
      .hdr_length (hdr_length),
      .hdr_addr   (hdr_addr),
      .hdr_word   (hdr_word),
      .tx_tdata   (tx_tdata),
      .tx_tkeep   (tx_tkeep),
      .tx_tlast   (tx_tlast),
      .tx_valid   (tx_valid),
      .tx_ready   (tx_ready)
   );

endmodule

/* test/tb_rdmx_xmit.sv */
// RDMX transmit path testbench, directed tests against a reference header model
module tb_rdmx_xmit;

   timeunit 1ns;
   timeprecision 1ps;

   // Header parameters, deliberately not the RTL defaults
   localparam logic [7:0]  src_mac_low     = 8'h5A;
   localparam logic [31:0] src_ip          = 32'hC0A8_0A01;
   localparam logic [31:0] dst_ip          = 32'hC0A8_0AFE;
   localparam logic [15:0] src_port        = 16'd4791;
   localparam logic [15:0] dst_port        = 16'd4792;
   localparam int          data_fifo_depth = 16;
   localparam int          meta_fifo_depth = 4;
   // About 60 beats of traffic plus random stalls, fill and reset fit well inside
   localparam int          max_cycles      = 4000;

   logic           dst_clk;
   logic           dst_resetn;
   logic [511:0]   data_tdata;
   logic           data_tlast;
   logic           data_valid;
   logic           data_ready;
   logic [15:0]    len_tdata;
   logic           len_valid;
   logic           len_ready;
   logic [63:0]    addr_tdata;
   logic           addr_valid;
   logic           addr_ready;
   logic [511:0]   tx_tdata;
   logic [63:0]    tx_tkeep;
   logic           tx_tlast;
   logic           tx_valid;
   logic           tx_ready;

   // Stimulus queues, beats are {last, data}
   logic [512:0]   data_q[$];
   logic [15:0]    len_q[$];
   logic [63:0]    addr_q[$];
   // Output beats are {last, keep, data}
   logic [576:0]   exp_q[$];
   logic [576:0]   rx_q[$];
   // 0 holds tx_ready low, 1 high, 2 random
   int             ready_mode;
   int             data_accepted;
   int             cycle_count;
   logic [31:0]    lcg_state;

   rdmx_xmit #(
      .src_mac_low     (src_mac_low),
      .src_ip          (src_ip),
      .dst_ip          (dst_ip),
      .src_port        (src_port),
      .dst_port        (dst_port),
      .data_fifo_depth (data_fifo_depth),
      .meta_fifo_depth (meta_fifo_depth)
   ) UUT (
      .dst_clk    (dst_clk),
      .dst_resetn (dst_resetn),
      .data_tdata (data_tdata),
      .data_tlast (data_tlast),
      .data_valid (data_valid),
      .data_ready (data_ready),
      .len_tdata  (len_tdata),
      .len_valid  (len_valid),
      .len_ready  (len_ready),
      .addr_tdata (addr_tdata),
      .addr_valid (addr_valid),
      .addr_ready (addr_ready),
      .tx_tdata   (tx_tdata),
      .tx_tkeep   (tx_tkeep),
      .tx_tlast   (tx_tlast),
      .tx_valid   (tx_valid),
      .tx_ready   (tx_ready)
   );

   // ========================================
   // Clock, timeout, monitor
   // ========================================
   initial begin
      dst_clk = 1'b0;
      forever #20 dst_clk = ~dst_clk;
   end

   always @(posedge dst_clk) begin
      cycle_count++;
      if (cycle_count >= max_cycles) begin
         $display("Timeout: the run did not finish within %0d clock cycles", max_cycles);
         $display("SIMULATION FAILED");
         $fatal(1, "Run stopped by the cycle limit");
      end
   end

   // Accepted output beats, sampled before the edge updates anything
   always @(posedge dst_clk) begin
      if (dst_resetn === 1'b1 && tx_valid === 1'b1 && tx_ready === 1'b1) begin
         rx_q.push_back({tx_tlast, tx_tkeep, tx_tdata});
      end
   end

   // ========================================
   // Helpers
   // ========================================
   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Header in wire order first, then byte 0 moved to bits 7:0
   function automatic logic [511:0] header_model(input logic [15:0] len,
                                                 input logic [63:0] addr);
      logic [511:0] wire_msb;
      logic [511:0] le_word;
      logic [15:0]  ip_len;
      logic [15:0]  udp_len;
      logic [31:0]  sum;
      logic [15:0]  csum;
      // IPv4 counts 20+8+22 bytes of headers, UDP 8+22
      ip_len  = 16'd50 + len;
      udp_len = 16'd30 + len;
      sum = 32'h4500 + 32'hDEAD + 32'h4000 + 32'h4011
          + src_ip[31:16] + src_ip[15:0] + dst_ip[31:16] + dst_ip[15:0] + ip_len;
      csum = ~(sum[15:0] + sum[31:16]);
      wire_msb = {48'hFFFF_FFFF_FFFF, 40'hC4_00AD_0000, src_mac_low, 16'h0800,
                  16'h4500, ip_len, 16'hDEAD, 16'h4000, 16'h4011, csum, src_ip, dst_ip,
                  src_port, dst_port, udp_len, 16'h0000,
                  16'h0122, addr, 96'h0};
      for (int i = 0; i < 64; i++) begin
         le_word[i*8 +: 8] = wire_msb[511 - i*8 -: 8];
      end
      return le_word;
   endfunction

   // Low len mod 64 bytes on a partial last beat
   function automatic logic [63:0] keep_mask(input logic [15:0] len, input logic last);
      if (!last || len[5:0] == 6'd0) begin
         return '1;
      end
      return (64'd1 << len[5:0]) - 64'd1;
   endfunction

   task automatic check(input string name, input logic [511:0] got, input logic [511:0] exp);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
         $display("SIMULATION FAILED");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   // Length, address and random payload, plus the beats expected back
   task automatic queue_packet(input logic [15:0] len, input logic [63:0] addr);
      int           beats;
      logic [511:0] d;
      logic         last;
      beats = (len + 63) / 64;
      len_q.push_back(len);
      addr_q.push_back(addr);
      exp_q.push_back({1'b0, {64{1'b1}}, header_model(len, addr)});
      for (int b = 0; b < beats; b++) begin
         for (int w = 0; w < 16; w++) begin
            d[w*32 +: 32] = lcg_next();
         end
         last = (b == beats - 1);
         data_q.push_back({last, d});
         exp_q.push_back({last, keep_mask(len, last), d});
      end
   endtask

   task automatic wait_for_beats();
      while (rx_q.size() < exp_q.size()) begin
         @(negedge dst_clk);
      end
   endtask

   task automatic compare_received();
      logic [576:0] got;
      logic [576:0] exp;
      int           beat;
      beat = 0;
      while (exp_q.size() > 0) begin
         got = rx_q.pop_front();
         exp = exp_q.pop_front();
         for (int i = 0; i < 64; i++) begin
            check($sformatf("tx_tdata byte %0d of beat %0d", i, beat),
                  got[i*8 +: 8], exp[i*8 +: 8]);
         end
         check($sformatf("tx_tkeep of beat %0d", beat), got[575:512], exp[575:512]);
         check($sformatf("tx_tlast of beat %0d", beat), got[576], exp[576]);
         beat++;
      end
      check("count of unexpected tx beats", rx_q.size(), 0);
   endtask

   // ========================================
   // Stream drivers
   // ========================================
   initial begin : stream_drivers
      logic        d_fire;
      logic        l_fire;
      logic        a_fire;
      logic [31:0] rnd;
      forever begin
         @(posedge dst_clk);
         d_fire = data_valid && data_ready;
         l_fire = len_valid && len_ready;
         a_fire = addr_valid && addr_ready;
         if (d_fire) begin
            data_accepted++;
         end
         @(negedge dst_clk);
         // Hold each beat until accepted
         if (!data_valid || d_fire) begin
            data_valid = (data_q.size() > 0);
            if (data_valid) begin
               {data_tlast, data_tdata} = data_q.pop_front();
            end
         end
         if (!len_valid || l_fire) begin
            len_valid = (len_q.size() > 0);
            if (len_valid) begin
               len_tdata = len_q.pop_front();
            end
         end
         if (!addr_valid || a_fire) begin
            addr_valid = (addr_q.size() > 0);
            if (addr_valid) begin
               addr_tdata = addr_q.pop_front();
            end
         end
         if (ready_mode == 2) begin
            rnd = lcg_next();
            tx_ready = rnd[23];
         end else begin
            tx_ready = (ready_mode == 1);
         end
      end
   end

   // ========================================
   // Directed tests
   // ========================================
   task automatic after_reset();
      check("tx_valid", tx_valid, 1'b0);
      check("len_ready", len_ready, 1'b1);
      check("addr_ready", addr_ready, 1'b1);
      check("data_ready", data_ready, 1'b1);
   endtask

   task automatic single_header();
      ready_mode = 1;
      queue_packet(16'd100, 64'h0123_4567_89AB_CDEF);
      wait_for_beats();
      compare_received();
   endtask

   // Full beat, 36-byte tail, 1-byte tail
   task automatic payload_keep();
      ready_mode = 1;
      queue_packet(16'd64, 64'h0000_0000_0000_1000);
      queue_packet(16'd100, 64'h0000_0000_0000_2040);
      queue_packet(16'd1, 64'hFFFF_0000_0000_3000);
      wait_for_beats();
      compare_received();
   endtask

   task automatic queued_packets();
      ready_mode = 0;
      queue_packet(16'd40, 64'h1111_2222_3333_4444);
      queue_packet(16'd130, 64'h5555_6666_7777_8888);
      queue_packet(16'd64, 64'h9999_AAAA_BBBB_CCCC);
      // Everything into the FIFOs before the output opens
      while (data_q.size() > 0 || len_q.size() > 0 || addr_q.size() > 0 ||
             data_valid || len_valid || addr_valid) begin
         @(negedge dst_clk);
      end
      // First header presented and held while the output is closed
      check("tx_valid with tx_ready low", tx_valid, 1'b1);
      check("held tx_tdata", tx_tdata, header_model(16'd40, 64'h1111_2222_3333_4444));
      ready_mode = 1;
      wait_for_beats();
      compare_received();
   endtask

   task automatic back_pressure();
      logic [31:0] saved_seed;
      saved_seed = lcg_state;
      ready_mode = 1;
      queue_packet(16'd200, 64'hDEAD_BEEF_0000_0001);
      queue_packet(16'd64, 64'hDEAD_BEEF_0000_0002);
      queue_packet(16'd5, 64'hDEAD_BEEF_0000_0003);
      wait_for_beats();
      compare_received();
      // Same packets again, stalled at random
      lcg_state = saved_seed;
      queue_packet(16'd200, 64'hDEAD_BEEF_0000_0001);
      queue_packet(16'd64, 64'hDEAD_BEEF_0000_0002);
      queue_packet(16'd5, 64'hDEAD_BEEF_0000_0003);
      ready_mode = 2;
      wait_for_beats();
      compare_received();
      ready_mode = 1;
   endtask

   task automatic fifo_fill();
      ready_mode = 0;
      data_accepted = 0;
      // 20 beats, more than the data FIFO holds
      queue_packet(16'd1280, 64'h0F0F_0F0F_0F0F_0F0F);
      while (data_ready) begin
         @(negedge dst_clk);
      end
      check("data beats accepted before data_ready fell", data_accepted, data_fifo_depth);
      ready_mode = 1;
      while (!data_ready) begin
         @(negedge dst_clk);
      end
      wait_for_beats();
      compare_received();
   endtask

   // ========================================
   // Main sequence
   // ========================================
   initial begin
      dst_resetn    = 1'b0;
      data_tdata    = '0;
      data_tlast    = 1'b0;
      data_valid    = 1'b0;
      len_tdata     = '0;
      len_valid     = 1'b0;
      addr_tdata    = '0;
      addr_valid    = 1'b0;
      tx_ready      = 1'b0;
      ready_mode    = 0;
      data_accepted = 0;
      cycle_count   = 0;
      lcg_state     = 32'hee2a_eeac;
      repeat (16) @(negedge dst_clk);
      dst_resetn = 1'b1;
      @(negedge dst_clk);
      after_reset();
      single_header();
      payload_keep();
      queued_packets();
      back_pressure();
      fifo_fill();
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

/* compile.f */
hw/rdmx_pkg.sv
hw/rdmx_stream_fifo.sv
hw/rdmx_header_builder.sv
hw/rdmx_tx_sequencer.sv
hw/rdmx_xmit.sv
test/tb_rdmx_xmit.sv

/* Bender.yml */
package:
  name: rdmx_xmit

sources:
  - hw/rdmx_pkg.sv
  - hw/rdmx_stream_fifo.sv
  - hw/rdmx_header_builder.sv
  - hw/rdmx_tx_sequencer.sv
  - hw/rdmx_xmit.sv
  - target: test
    files:
      - test/tb_rdmx_xmit.sv
